// File: compile.f
subsystem_regmap_pkg.sv
servo_timing_pkg.sv
spi_target.sv
reg_file.sv
servo_channel.sv
servo_bank.sv
fpga_subsystem.sv
tb_fpga_subsystem.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f --top-module tb_fpga_subsystem \
    -Mdir obj_dir -o tb_sim

# The simulator exits non-zero on a fatal error, tee keeps the pipeline going
./obj_dir/tb_sim | tee sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi

if ! grep -q "sim passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi

echo "Simulation completed without errors"

// File: tb_fpga_subsystem.sv
// Directed testbench for the host side, SPI host runs at 8 clocks per half period
// PWM widths are counted in clocks on falling clock edges, stops at the first error
module tb_fpga_subsystem;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int half_period   = 8;               // Clocks per SPI half period
    localparam int period_clocks = servo_timing_pkg::servo_period_ticks
                                   * servo_timing_pkg::servo_tick_div;
    localparam int max_cycles    = 200000;          // About 60 PWM periods plus SPI, with margin

    logic       clock;
    logic       reset_n;
    logic       spi_clock, cs_n, mosi, miso;
    logic [3:0] motor_fault;
    logic [3:0] servo_pwm;
    logic       status_fault, status_pi, status_ps4, status_debug;
    logic [31:0] lfsr_state;                        // Random data source
    int         cycle_count = 0;

    fpga_subsystem dut0 (
        .clock(clock), .reset_n(reset_n),
        .spi_clock(spi_clock), .cs_n(cs_n), .mosi(mosi), .miso(miso),
        .motor_fault(motor_fault), .servo_pwm(servo_pwm),
        .status_fault(status_fault), .status_pi(status_pi),
        .status_ps4(status_ps4), .status_debug(status_debug)
    );

    always #50 clock = ~clock;                      // 100 ns period

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            abort_run($sformatf("Timeout, the tests did not finish in %0d cycles", max_cycles));
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks and random data
    ////////////////////////////////////////////////////////////////////////////
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic next_random_byte(output logic [7:0] value);
        value = '0;
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);     // One step per bit
            value      = {value[6:0], lfsr_state[0]};
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // SPI host and PWM measurement
    ////////////////////////////////////////////////////////////////////////////
    task automatic step_clocks(input int count);
        repeat (count) @(posedge clock);
        #10;                                        // Drive point after the edge
    endtask

    // Mode 0, mosi set while spi_clock is low, miso sampled just before the rise
    task automatic shift_frame(input logic [15:0] frame, output logic [7:0] rx);
        rx = '0;
        step_clocks(1);
        cs_n = 1'b0;
        for (int i = 15; i >= 0; i--) begin
            mosi = frame[i];
            step_clocks(half_period);
            if (i < 8) begin
                rx = {rx[6:0], miso};               // Data byte, MSB first
            end
            spi_clock = 1'b1;
            step_clocks(half_period);
            spi_clock = 1'b0;
        end
        step_clocks(half_period);
        cs_n = 1'b1;
        mosi = 1'b0;
        step_clocks(half_period);                   // Gap between frames
    endtask

    task automatic spi_write(input logic [5:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        shift_frame({2'b00, addr, data}, unused);
    endtask

    task automatic spi_read(input logic [5:0] addr, output logic [7:0] data);
        shift_frame({2'b10, addr, 8'h00}, data);
    endtask

    task automatic measure_pulse(input int channel, output int width);
        int waited;
        waited = 0;
        width  = 0;
        @(negedge clock);
        while (servo_pwm[channel] !== 1'b0) begin  // Skip a pulse already running
            @(negedge clock);
        end
        while (servo_pwm[channel] !== 1'b1) begin
            @(negedge clock);
            waited++;
            if (waited > 2 * period_clocks) begin
                abort_run($sformatf("Servo %0d produced no pulse within two periods", channel));
            end
        end
        while (servo_pwm[channel] === 1'b1) begin
            width++;
            @(negedge clock);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic reset_and_protection();
        logic [7:0] data;
        @(negedge clock);
        check_value("servo_pwm", servo_pwm, 4'h0);
        check_value("status_pi", status_pi, 1'b0);
        check_value("status_ps4", status_ps4, 1'b0);
        check_value("status_debug", status_debug, 1'b1);
        spi_read(subsystem_regmap_pkg::addr_servo_control, data);
        check_value("servo_control", data, 8'h00);
        spi_write(subsystem_regmap_pkg::addr_id, 8'h3C);    // Read only
        spi_read(subsystem_regmap_pkg::addr_id, data);
        check_value("id", data, 8'hA5);
        spi_read(6'h20, data);                      // Unmapped
        check_value("unmapped 0x20", data, 8'h00);
    endtask

    task automatic register_access();
        logic [7:0] data, value;
        spi_read(subsystem_regmap_pkg::addr_id, data);
        check_value("id", data, 8'hA5);
        for (int i = 0; i < 5; i++) begin
            next_random_byte(value);
            spi_write(subsystem_regmap_pkg::addr_scratch, value);
            spi_read(subsystem_regmap_pkg::addr_scratch, data);
            check_value("scratch", data, value);
        end
    endtask

    task automatic direct_servo_pulses();
        int width;
        spi_write(subsystem_regmap_pkg::addr_servo_position1, 8'd64);
        spi_write(subsystem_regmap_pkg::addr_servo_control, 8'h02);     // Wrist only
        for (int i = 0; i < 3; i++) begin
            measure_pulse(1, width);
            check_value("servo_pwm[1] width", width, 64 * servo_timing_pkg::servo_tick_div);
            repeat (period_clocks) begin            // Disabled servos low all period
                @(negedge clock);
                check_value("servo_pwm[0]", servo_pwm[0], 1'b0);
                check_value("servo_pwm[3:2]", servo_pwm[3:2], 2'b00);
            end
        end
    endtask

    task automatic ramped_servo_pulses();
        int width;
        int ratio;
        spi_write(subsystem_regmap_pkg::addr_servo_control, 8'h00);
        spi_write(subsystem_regmap_pkg::addr_servo_position0, 8'd12);
        fork                                        // First pulse follows the enable closely
            spi_write(subsystem_regmap_pkg::addr_servo_control, 8'h01);
            measure_pulse(0, width);
        join
        ratio = servo_timing_pkg::servo_start_ratio;
        check_value("servo_pwm[0] width", width, ratio * servo_timing_pkg::servo_tick_div);
        for (int i = 0; i < 9; i++) begin
            if (ratio < 12) begin
                ratio++;                            // One step per period
            end
            measure_pulse(0, width);
            check_value("servo_pwm[0] width", width, ratio * servo_timing_pkg::servo_tick_div);
        end
    endtask

    task automatic status_led_modes();
        logic [7:0] data;
        spi_write(subsystem_regmap_pkg::addr_led_control, 8'h00);
        check_value("status_fault", status_fault, 1'b0);
        check_value("status_debug", status_debug, 1'b1);
        motor_fault = 4'h4;
        step_clocks(4);                             // Through the synchronizer
        check_value("status_fault", status_fault, 1'b1);
        spi_read(subsystem_regmap_pkg::addr_fault_status, data);
        check_value("fault_status", data, 8'h04);
        spi_write(subsystem_regmap_pkg::addr_led_control, 8'h18);       // Pi and PS4 bits
        check_value("status_pi", status_pi, 1'b1);
        check_value("status_ps4", status_ps4, 1'b1);
        spi_write(subsystem_regmap_pkg::addr_led_control, 8'h05);
        check_value("status_fault", status_fault, 1'b0);                // Fault bit clear
        check_value("status_pi", status_pi, 1'b1);
        check_value("status_ps4", status_ps4, 1'b1);
        check_value("status_debug", status_debug, 1'b1);                // Motor hot bit
        spi_write(subsystem_regmap_pkg::addr_led_control, 8'h07);
        check_value("status_fault", status_fault, 1'b1);
        spi_write(subsystem_regmap_pkg::addr_led_control, 8'h01);
        check_value("status_fault", status_fault, 1'b0);
        check_value("status_debug", status_debug, 1'b0);
    endtask

    initial begin
        clock       = 1'b0;
        reset_n     = 1'b0;
        spi_clock   = 1'b0;
        cs_n        = 1'b1;
        mosi        = 1'b0;
        motor_fault = 4'h0;
        lfsr_state  = 32'd78498;
        repeat (3) @(posedge clock);
        #10;
        reset_n = 1'b1;
        reset_and_protection();
        register_access();
        direct_servo_pulses();
        ramped_servo_pulses();
        status_led_modes();
        $display("sim passed");
        $finish;
    end

endmodule

// File: fpga_subsystem.sv
// Host side of the robot FPGA, SPI registers, arm servos and status LEDs
// reset_n comes from the board, everything runs on clock
module fpga_subsystem (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        spi_clock,
    input  logic        cs_n,
    input  logic        mosi,
    output logic        miso,
    input  logic [3:0]  motor_fault,
    output logic [servo_timing_pkg::servo_channels-1:0] servo_pwm,
    output logic        status_fault,
    output logic        status_pi,
    output logic        status_ps4,
    output logic        status_debug
);

    logic [subsystem_regmap_pkg::reg_addr_width-1:0] address;
    logic [subsystem_regmap_pkg::reg_data_width-1:0] wr_data, rd_data;
    logic       write_en, read_en;
    logic [3:0] servo_enable;
    logic [7:0] servo_position0, servo_position1, servo_position2, servo_position3;

    ////////////////////////////////////////////////////////////////////////////
    // Host port and registers
    ////////////////////////////////////////////////////////////////////////////
    spi_target spi0 (
        .clock(clock), .reset_n(reset_n),
        .spi_clock(spi_clock), .cs_n(cs_n), .mosi(mosi), .miso(miso),
        .address(address), .write_en(write_en), .wr_data(wr_data),
        .read_en(read_en), .rd_data(rd_data)
    );

    reg_file regs0 (
        .clock(clock), .reset_n(reset_n),
        .address(address), .write_en(write_en), .wr_data(wr_data),
        .read_en(read_en), .rd_data(rd_data),
        .motor_fault(motor_fault), .servo_enable(servo_enable),
        .servo_position0(servo_position0), .servo_position1(servo_position1),
        .servo_position2(servo_position2), .servo_position3(servo_position3),
        .status_fault(status_fault), .status_pi(status_pi),
        .status_ps4(status_ps4), .status_debug(status_debug)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Arm servos
    ////////////////////////////////////////////////////////////////////////////
    servo_bank servos0 (
        .clock(clock), .reset_n(reset_n), .servo_enable(servo_enable),
        .servo_position0(servo_position0), .servo_position1(servo_position1),
        .servo_position2(servo_position2), .servo_position3(servo_position3),
        .servo_pwm(servo_pwm)
    );

endmodule

// File: servo_bank.sv
// Four arm servos sharing one PWM tick, base and center are ramped
module servo_bank (
    input  logic        clock,
    input  logic        reset_n,
    input  logic [servo_timing_pkg::servo_channels-1:0]    servo_enable,
    input  logic [servo_timing_pkg::servo_ratio_width-1:0] servo_position0,
    input  logic [servo_timing_pkg::servo_ratio_width-1:0] servo_position1,
    input  logic [servo_timing_pkg::servo_ratio_width-1:0] servo_position2,
    input  logic [servo_timing_pkg::servo_ratio_width-1:0] servo_position3,
    output logic [servo_timing_pkg::servo_channels-1:0]    servo_pwm
);

    logic [$clog2(servo_timing_pkg::servo_tick_div)-1:0] div_count;
    logic tick;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            div_count <= '0;
            tick      <= 1'b0;
        end else begin
            tick <= (div_count == servo_timing_pkg::servo_tick_div - 1);
            if (div_count == servo_timing_pkg::servo_tick_div - 1) begin
                div_count <= '0;
            end else begin
                div_count <= div_count + 1'b1;
            end
        end
    end

    servo_channel #(.ramp_enable(1'b1)) base_servo (    // Ramped
        .clock(clock), .reset_n(reset_n), .tick(tick), .enable(servo_enable[0]),
        .target_ratio(servo_position0), .servo_pwm(servo_pwm[0])
    );

    servo_channel #(.ramp_enable(1'b0)) wrist_servo (   // Direct
        .clock(clock), .reset_n(reset_n), .tick(tick), .enable(servo_enable[1]),
        .target_ratio(servo_position1), .servo_pwm(servo_pwm[1])
    );

    servo_channel #(.ramp_enable(1'b1)) center_servo (  // Ramped
        .clock(clock), .reset_n(reset_n), .tick(tick), .enable(servo_enable[2]),
        .target_ratio(servo_position2), .servo_pwm(servo_pwm[2])
    );

    servo_channel #(.ramp_enable(1'b0)) grabber_servo ( // Direct
        .clock(clock), .reset_n(reset_n), .tick(tick), .enable(servo_enable[3]),
        .target_ratio(servo_position3), .servo_pwm(servo_pwm[3])
    );

endmodule

// File: servo_channel.sv
// One servo PWM output, ratio in ticks out of a 256 tick period
// Ratio loads only at period start, ramped version steps one per period
module servo_channel #(
    parameter bit ramp_enable = 1'b0                // 1 ramps toward target
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        tick,                       // One clock every tick_div
    input  logic        enable,
    input  logic [servo_timing_pkg::servo_ratio_width-1:0] target_ratio,
    output logic        servo_pwm
);

    logic [$clog2(servo_timing_pkg::servo_period_ticks)-1:0] count;
    logic [servo_timing_pkg::servo_ratio_width-1:0] ratio, next_ratio;
    logic running;                                  // First tick seen since enable

    always_comb begin
        if (!ramp_enable) begin
            next_ratio = target_ratio;
        end else if (ratio < target_ratio) begin
            next_ratio = ratio + 1'b1;
        end else if (ratio > target_ratio) begin
            next_ratio = ratio - 1'b1;
        end else begin
            next_ratio = ratio;                     // Holds once there
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count   <= '0;
            running <= 1'b0;
            ratio   <= servo_timing_pkg::servo_start_ratio;
        end else if (!enable) begin
            count   <= '0;                          // Parked at period start
            running <= 1'b0;
            ratio   <= ramp_enable ? servo_timing_pkg::servo_start_ratio : target_ratio;
        end else if (tick) begin
            running <= 1'b1;
            if (running) begin
                if (count == servo_timing_pkg::servo_period_ticks - 1) begin
                    count <= '0;
                    ratio <= next_ratio;            // New period, new ratio
                end else begin
                    count <= count + 1'b1;
                end
            end
        end
    end

    // First period starts on a tick so its width is exact
    assign servo_pwm = enable && running && (count < ratio);

    if (ramp_enable) begin : g_ramp_check
        // A ramped servo never jumps while enabled
        assert property (@(posedge clock) disable iff (!reset_n)
            ($past(enable) && ratio != $past(ratio)) |->
            (ratio == $past(ratio) + 1'b1 || ratio == $past(ratio) - 1'b1))
            else $error("ramped servo ratio jumped");
    end

endmodule

// File: reg_file.sv
// Configuration and status registers, every access completes in one cycle
// Writes to read-only or unmapped addresses are ignored
module reg_file (
    input  logic        clock,
    input  logic        reset_n,
    input  logic [subsystem_regmap_pkg::reg_addr_width-1:0] address,
    input  logic        write_en,
    input  logic [subsystem_regmap_pkg::reg_data_width-1:0] wr_data,
    input  logic        read_en,
    output logic [subsystem_regmap_pkg::reg_data_width-1:0] rd_data,
    input  logic [3:0]  motor_fault,                // Async, from motor drivers
    output logic [3:0]  servo_enable,
    output logic [7:0]  servo_position0,
    output logic [7:0]  servo_position1,
    output logic [7:0]  servo_position2,
    output logic [7:0]  servo_position3,
    output logic        status_fault,
    output logic        status_pi,
    output logic        status_ps4,
    output logic        status_debug
);

    logic [7:0] scratch, servo_control, led_control;
    logic [3:0] fault_meta, fault_sync;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            scratch         <= '0;
            servo_control   <= '0;
            led_control     <= '0;
            servo_position0 <= '0;
            servo_position1 <= '0;
            servo_position2 <= '0;
            servo_position3 <= '0;
        end else if (write_en) begin
            case (address)
                subsystem_regmap_pkg::addr_scratch:         scratch         <= wr_data;
                subsystem_regmap_pkg::addr_servo_control:   servo_control   <= wr_data;
                subsystem_regmap_pkg::addr_led_control:     led_control     <= wr_data;
                subsystem_regmap_pkg::addr_servo_position0: servo_position0 <= wr_data;
                subsystem_regmap_pkg::addr_servo_position1: servo_position1 <= wr_data;
                subsystem_regmap_pkg::addr_servo_position2: servo_position2 <= wr_data;
                subsystem_regmap_pkg::addr_servo_position3: servo_position3 <= wr_data;
                default: ;                          // ID, fault status, unmapped
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read mux, registered on the strobe
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_data <= '0;
        end else if (read_en) begin
            case (address)
                subsystem_regmap_pkg::addr_id:              rd_data <= subsystem_regmap_pkg::id_value;
                subsystem_regmap_pkg::addr_scratch:         rd_data <= scratch;
                subsystem_regmap_pkg::addr_servo_control:   rd_data <= servo_control;
                subsystem_regmap_pkg::addr_led_control:     rd_data <= led_control;
                subsystem_regmap_pkg::addr_servo_position0: rd_data <= servo_position0;
                subsystem_regmap_pkg::addr_servo_position1: rd_data <= servo_position1;
                subsystem_regmap_pkg::addr_servo_position2: rd_data <= servo_position2;
                subsystem_regmap_pkg::addr_servo_position3: rd_data <= servo_position3;
                subsystem_regmap_pkg::addr_fault_status:    rd_data <= {4'b0, fault_sync};
                default:                                    rd_data <= '0;
            endcase
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fault_meta <= '0;
            fault_sync <= '0;
        end else begin
            fault_meta <= motor_fault;              // Two flop synchronizer
            fault_sync <= fault_meta;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Servo enables and status LEDs
    ////////////////////////////////////////////////////////////////////////////
    assign servo_enable = servo_control[3:0];       // Upper bits stored only

    always_comb begin
        if (led_control[subsystem_regmap_pkg::led_test_bit]) begin
            status_fault = led_control[subsystem_regmap_pkg::led_fault_bit];
            status_pi    = 1'b1;
            status_ps4   = 1'b1;
            status_debug = led_control[subsystem_regmap_pkg::led_hot_bit];
        end else begin
            status_fault = |fault_sync;             // Live fault state
            status_pi    = led_control[subsystem_regmap_pkg::led_pi_bit];
            status_ps4   = led_control[subsystem_regmap_pkg::led_ps4_bit];
            status_debug = 1'b1;
        end
    end

    // Target needs a full header byte between read strobes
    assert property (@(posedge clock) disable iff (!reset_n) read_en |=> !read_en)
        else $error("read strobe on back to back cycles");

endmodule

// File: spi_target.sv
// SPI mode 0 target, 16-bit frames MSB first, spi_clock at most clock / 8
// A frame cut short by cs_n is dropped and never writes
module spi_target (
    input  logic        clock,
    input  logic        reset_n,
    input  logic        spi_clock,                  // Host clock, async
    input  logic        cs_n,
    input  logic        mosi,
    output logic        miso,
    output logic [subsystem_regmap_pkg::reg_addr_width-1:0] address,
    output logic        write_en,
    output logic [subsystem_regmap_pkg::reg_data_width-1:0] wr_data,
    output logic        read_en,
    input  logic [subsystem_regmap_pkg::reg_data_width-1:0] rd_data
);

    logic [subsystem_regmap_pkg::spi_sync_stages-1:0] clk_sync, cs_sync, mosi_sync;
    logic        clk_prev;                          // Last synced spi_clock
    logic        cs_active, rise, fall;
    logic        mosi_s;
    logic [subsystem_regmap_pkg::spi_frame_bits-1:0] shift;
    logic [$clog2(subsystem_regmap_pkg::spi_frame_bits)-1:0] bit_cnt;
    logic [subsystem_regmap_pkg::spi_header_bits-1:0] header_next;
    logic        read_frame;                        // Current frame is a read
    logic [2:0]  wr_pipe;                           // Write strobe delay
    logic        rd_load;
    logic [subsystem_regmap_pkg::reg_data_width-1:0] tx_shift;

    ////////////////////////////////////////////////////////////////////////////
    // Pin synchronizers and edge detect
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            clk_sync  <= '0;
            cs_sync   <= '1;                        // Deselected
            mosi_sync <= '0;
            clk_prev  <= 1'b0;
        end else begin
            clk_sync  <= {clk_sync[$high(clk_sync)-1:0], spi_clock};
            cs_sync   <= {cs_sync[$high(cs_sync)-1:0], cs_n};
            mosi_sync <= {mosi_sync[$high(mosi_sync)-1:0], mosi};
            clk_prev  <= clk_sync[$high(clk_sync)];
        end
    end

    assign cs_active = !cs_sync[$high(cs_sync)];
    assign rise      = cs_active && clk_sync[$high(clk_sync)] && !clk_prev;
    assign fall      = cs_active && !clk_sync[$high(clk_sync)] && clk_prev;
    assign mosi_s    = mosi_sync[$high(mosi_sync)];
    assign header_next = {shift[subsystem_regmap_pkg::spi_header_bits-2:0], mosi_s};

    always_ff @(posedge clock) begin
        if (rise) begin
            shift <= {shift[subsystem_regmap_pkg::spi_frame_bits-2:0], mosi_s};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Frame control and register strobes
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            bit_cnt    <= '0;
            read_frame <= 1'b0;
            address    <= '0;
            read_en    <= 1'b0;
            wr_pipe    <= '0;
        end else begin
            read_en <= 1'b0;
            wr_pipe <= {wr_pipe[1:0], 1'b0};
            if (!cs_active) begin
                bit_cnt    <= '0;                   // Aborts a partial frame
                read_frame <= 1'b0;
            end else if (rise) begin
                bit_cnt <= bit_cnt + 1'b1;          // Wraps after bit 16
                if (bit_cnt == subsystem_regmap_pkg::spi_header_bits - 1) begin
                    read_frame <= header_next[subsystem_regmap_pkg::spi_rw_bit
                                              - subsystem_regmap_pkg::spi_header_bits];
                    read_en    <= header_next[subsystem_regmap_pkg::spi_rw_bit
                                              - subsystem_regmap_pkg::spi_header_bits];
                    address    <= header_next[subsystem_regmap_pkg::reg_addr_width-1:0];
                end
                if (bit_cnt == subsystem_regmap_pkg::spi_frame_bits - 1) begin
                    wr_pipe[0] <= !read_frame;
                end
            end
        end
    end

    assign write_en = wr_pipe[2];                   // 3 clocks after last rise
    assign wr_data  = shift[subsystem_regmap_pkg::reg_data_width-1:0];

    ////////////////////////////////////////////////////////////////////////////
    // Read data out, changes on falling spi_clock
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (rd_load) begin
            tx_shift <= rd_data;
        end else if (fall) begin
            tx_shift <= {tx_shift[$high(tx_shift)-1:0], 1'b0};
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            rd_load <= 1'b0;
            miso    <= 1'b0;
        end else begin
            rd_load <= read_en;                     // rd_data valid now
            if (!cs_active) begin
                miso <= 1'b0;
            end else if (fall) begin
                miso <= read_frame && (bit_cnt >= subsystem_regmap_pkg::spi_header_bits)
                        && tx_shift[$high(tx_shift)];
            end
        end
    end

    // Read strobe comes mid-frame, write strobe after the frame
    assert property (@(posedge clock) disable iff (!reset_n) !(write_en && read_en))
        else $error("read and write strobes together");

endmodule

// File: servo_timing_pkg.sv
// Arm servo PWM timing, one period is 256 ticks of 4 clocks each
package servo_timing_pkg;

    localparam int servo_tick_div     = 4;          // Clocks per PWM tick
    localparam int servo_period_ticks = 256;        // Ticks per PWM period
    localparam int servo_ratio_width  = 8;
    localparam int servo_channels     = 4;          // Base, wrist, center, grabber

    // Ramp start ratio, also the value after reset
    localparam logic [servo_ratio_width-1:0] servo_start_ratio = 8'd5;

endpackage

// File: subsystem_regmap_pkg.sv
// Register map and SPI frame layout of the host interface
// 6-bit addresses, 8-bit registers, unmapped addresses read as zero
package subsystem_regmap_pkg;

    localparam int reg_addr_width  = 6;             // Register address bits
    localparam int reg_data_width  = 8;             // Register data bits
    localparam int spi_frame_bits  = 16;            // Bits per cs_n frame
    localparam int spi_sync_stages = 2;             // Flops behind each SPI pin
    localparam int spi_header_bits = 8;             // R/W flag plus address
    localparam int spi_rw_bit      = 15;            // Set for read

    ////////////////////////////////////////////////////////////////////////////
    // Register addresses
    ////////////////////////////////////////////////////////////////////////////
    localparam logic [reg_addr_width-1:0] addr_id              = 6'h00; // Read only
    localparam logic [reg_addr_width-1:0] addr_scratch         = 6'h01;
    localparam logic [reg_addr_width-1:0] addr_servo_control   = 6'h02; // Servo enables
    localparam logic [reg_addr_width-1:0] addr_led_control     = 6'h03;
    localparam logic [reg_addr_width-1:0] addr_servo_position0 = 6'h04; // Base
    localparam logic [reg_addr_width-1:0] addr_servo_position1 = 6'h05; // Wrist
    localparam logic [reg_addr_width-1:0] addr_servo_position2 = 6'h06; // Center
    localparam logic [reg_addr_width-1:0] addr_servo_position3 = 6'h07; // Grabber
    localparam logic [reg_addr_width-1:0] addr_fault_status    = 6'h08; // Read only

    localparam logic [reg_data_width-1:0] id_value = 8'hA5;

    // LED control bit positions
    localparam int led_test_bit  = 0;               // Test mode
    localparam int led_fault_bit = 1;
    localparam int led_hot_bit   = 2;               // Motor hot
    localparam int led_pi_bit    = 3;               // Pi connected
    localparam int led_ps4_bit   = 4;               // PS4 connected

endpackage
